// File: dv/cpu_tb.sv
`timescale 1ns/1ns

module cpu_tb
    import cpu_pkg::*;
();

    localparam int prog_len       = 200;
    localparam int timeout_cycles = prog_len * 5 * 2;

    localparam logic [31:0] data_base = 32'h1c01_0000;
    localparam logic [31:0] final_pc  = reset_pc + 32'(4 * (prog_len - 1));

    typedef enum {
        k_3r, k_shift, k_addi, k_lu12i, k_ld, k_st, k_beq, k_bne, k_b, k_bl, k_jirl
    } inst_kind_e;

    logic        clk;
    logic        reset;
    logic [31:0] inst_addr, inst_rdata;
    logic        data_we;
    logic [31:0] data_addr, data_wdata, data_rdata;
    logic [31:0] wb_pc, wb_rf_wdata;
    logic        wb_rf_we;
    logic [4:0]  wb_rf_wnum;

    logic [31:0] imem [0:prog_len-1];
    logic [31:0] dmem [0:255];
    logic [31:0] inst_off;
    logic [7:0]  dmem_idx;

    // program as the model sees it
    inst_kind_e  p_kind [0:prog_len-1];
    int          p_f    [0:prog_len-1];
    logic [4:0]  p_rd   [0:prog_len-1];
    logic [4:0]  p_rj   [0:prog_len-1];
    logic [4:0]  p_rk   [0:prog_len-1];
    logic [31:0] p_imm  [0:prog_len-1];
    bit          landing [0:prog_len-1];

    logic [31:0] m_regs [0:31];
    logic [31:0] m_mem  [0:255];
    logic [31:0] exp_pc [$];
    logic [4:0]  exp_num [$];
    logic [31:0] exp_val [$];
    logic [31:0] exp_st_addr [$];
    logic [31:0] exp_st_data [$];
    int          exp_writes, exp_stores;

    logic [31:0] rng_state = 32'd21682;
    int          cycles, trace_cnt, store_cnt;
    bit          fetch_seen;

    cpu_top dut_i (
        .clk(clk), .reset(reset),
        .inst_addr(inst_addr), .inst_rdata(inst_rdata),
        .data_we(data_we), .data_addr(data_addr),
        .data_wdata(data_wdata), .data_rdata(data_rdata),
        .wb_pc(wb_pc), .wb_rf_we(wb_rf_we),
        .wb_rf_wnum(wb_rf_wnum), .wb_rf_wdata(wb_rf_wdata)
    );

    always #20 clk = ~clk;

    assign inst_off   = (inst_addr - reset_pc) >> 2;
    assign inst_rdata = (inst_off < prog_len) ? imem[inst_off[7:0]] : 32'd0;
    assign dmem_idx   = data_addr[9:2]; // base is 1 KB aligned
    assign data_rdata = dmem[dmem_idx];

    always @(posedge clk) begin
        if (data_we) begin
            dmem[dmem_idx] <= data_wdata;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function int unsigned rand_below(input int unsigned n);
        rng_state = xorshift(rng_state);
        return rng_state % n;
    endfunction

    // r2 holds the data base, never a destination
    function automatic logic [4:0] pick_dest();
        logic [4:0] r;
        r = 5'(rand_below(32));
        return (r == 5'd2) ? 5'd0 : r;
    endfunction

    function automatic logic [31:0] fill_word(input int w);
        logic [31:0] addr;
        addr = data_base + 32'(w * 4);
        return addr ^ 32'h5a3c_96e1 ^ {addr[15:0], addr[31:16]};
    endfunction

    function automatic logic [7:0] word_index(input logic [31:0] addr);
        logic [31:0] off;
        off = (addr - data_base) >> 2;
        return off[7:0];
    endfunction

    // f: 0 add, 1 sub, 2 slt, 3 sltu, 4 nor, 5 and, 6 or, 7 xor, 8 sll, 9 srl, 10 sra
    function automatic logic [31:0] alu_model(input int f, input logic [31:0] a,
                                              input logic [31:0] b);
        case (f)
            0: return a + b;
            1: return a - b;
            2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3: return (a < b) ? 32'd1 : 32'd0;
            4: return ~(a | b);
            5: return a & b;
            6: return a | b;
            7: return a ^ b;
            8: return a << b[4:0];
            9: return a >> b[4:0];
            default: return $unsigned($signed(a) >>> b[4:0]);
        endcase
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("Something failed");
            $fatal(1, "stopping at the first error");
        end
    endtask

    task automatic abort_run(input string why);
        $display("error at %0t ns: %s", $time, why);
        $display("Something failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic put_inst(input int idx, input logic [31:0] word, input inst_kind_e kind,
                            input int f, input logic [4:0] rd, input logic [4:0] rj,
                            input logic [4:0] rk, input logic [31:0] imm);
        imem[idx]   = word;
        p_kind[idx] = kind;
        p_f[idx]    = f;
        p_rd[idx]   = rd;
        p_rj[idx]   = rj;
        p_rk[idx]   = rk;
        p_imm[idx]  = imm;
    endtask

    task automatic emit_3r(input int idx, input int f, input logic [4:0] rd,
                           input logic [4:0] rj, input logic [4:0] rk);
        logic [4:0] op;
        case (f)
            0: op = opc_add_w;
            1: op = opc_sub_w;
            2: op = opc_slt;
            3: op = opc_sltu;
            4: op = opc_nor;
            5: op = opc_and;
            6: op = opc_or;
            default: op = opc_xor;
        endcase
        put_inst(idx, {opc_alu, opc_3r, opc_3r_grp, op, rk, rj, rd}, k_3r, f, rd, rj, rk, 32'd0);
    endtask

    task automatic emit_shift(input int idx, input int f, input logic [4:0] rd,
                              input logic [4:0] rj, input logic [4:0] ui5);
        logic [4:0] op;
        op = (f == 8) ? opc_slli_w : (f == 9) ? opc_srli_w : opc_srai_w;
        put_inst(idx, {opc_alu, opc_shift, opc_shift_grp, op, ui5, rj, rd}, k_shift, f,
                 rd, rj, 5'd0, {27'd0, ui5});
    endtask

    task automatic emit_i12(input int idx, input inst_kind_e kind, input logic [4:0] rd,
                            input logic [4:0] rj, input logic [11:0] si12);
        logic [9:0] opc;
        case (kind)
            k_ld:    opc = {opc_mem, opc_ld_w};
            k_st:    opc = {opc_mem, opc_st_w};
            default: opc = {opc_alu, opc_addi_w};
        endcase
        put_inst(idx, {opc, si12, rj, rd}, kind, 0, rd, rj, 5'd0, {{20{si12[11]}}, si12});
    endtask

    task automatic emit_lu12i(input int idx, input logic [4:0] rd, input logic [19:0] si20);
        put_inst(idx, {opc_lu12i_w, 1'b0, si20, rd}, k_lu12i, 0, rd, 5'd0, 5'd0,
                 {si20, 12'd0});
    endtask

    // offset counted in instructions, forward only
    task automatic emit_branch(input int idx, input inst_kind_e kind, input logic [4:0] rd,
                               input logic [4:0] rj, input logic [25:0] words);
        logic [5:0]  opc;
        logic [31:0] word;
        case (kind)
            k_beq:   opc = opc_beq;
            k_bne:   opc = opc_bne;
            k_b:     opc = opc_b;
            k_bl:    opc = opc_bl;
            default: opc = opc_jirl;
        endcase
        if (kind == k_b || kind == k_bl) begin
            word = {opc, words[15:0], words[25:16]};
        end else begin
            word = {opc, words[15:0], rj, rd};
        end
        put_inst(idx, word, kind, 0, (kind == k_bl) ? 5'd1 : rd, rj, 5'd0,
                 {4'd0, words, 2'b00});
    endtask

    task automatic build_program();
        int          i, kind, k, t, off;
        logic [4:0]  rd, rj, rk, tmp;
        logic [31:0] target;
        for (int n = 0; n < prog_len; n++) begin
            landing[n] = 1'b0;
        end
        emit_lu12i(0, 5'd2, data_base[31:12]);
        emit_i12(1, k_addi, 5'd2, 5'd2, 12'h100);
        i = 2;
        for (int r = 1; r < 32; r++) begin // known start value everywhere
            if (r == 2) begin
                continue;
            end
            if (r % 2 == 1) begin
                emit_i12(i, k_addi, 5'(r), 5'd0, 12'(rand_below(4096)));
            end else begin
                emit_lu12i(i, 5'(r), 20'(rand_below(1 << 20)));
            end
            i++;
        end
        while (i < prog_len - 1) begin
            kind = int'(rand_below(20));
            rd   = pick_dest();
            rj   = 5'(rand_below(32));
            rk   = 5'(rand_below(32));
            off  = int'(rand_below(128)) * 4 - 256;
            if (kind == 19 && i + 3 < prog_len - 1 && !landing[i + 1] && !landing[i + 2]) begin
                t = i + 3 + int'(rand_below(4));
                if (t > prog_len - 1) begin
                    t = prog_len - 1;
                end
                landing[t] = 1'b1;
                target = reset_pc + 32'(4 * t);
                tmp    = 5'(3 + rand_below(29));
                emit_lu12i(i, tmp, 20'((target + 32'h800) >> 12));
                emit_i12(i + 1, k_addi, tmp, tmp, target[11:0]);
                emit_branch(i + 2, k_jirl, rd, tmp, 26'd0);
                i += 3;
            end else if (kind >= 15 && kind <= 18) begin
                k = 1 + int'(rand_below(4));
                if (i + k > prog_len - 1) begin
                    k = prog_len - 1 - i;
                end
                landing[i + k] = 1'b1;
                if (rand_below(4) == 0) begin
                    rd = rj; // forces beq taken
                end
                if (kind == 15) begin
                    emit_branch(i, k_beq, rd, rj, 26'(k));
                end else if (kind == 16) begin
                    emit_branch(i, k_bne, rd, rj, 26'(k));
                end else begin
                    emit_branch(i, (kind == 17) ? k_b : k_bl, rd, rj, 26'(k));
                end
                i++;
            end else begin
                if (kind < 8) begin
                    emit_3r(i, kind, rd, rj, rk);
                end else if (kind < 11) begin
                    emit_shift(i, kind, rd, rj, rk);
                end else if (kind == 12) begin
                    emit_lu12i(i, rd, 20'(rand_below(1 << 20)));
                end else if (kind == 13) begin
                    emit_i12(i, k_ld, rd, 5'd2, 12'(off));
                end else if (kind == 14) begin
                    emit_i12(i, k_st, rj, 5'd2, 12'(off)); // rd field is the store data
                end else begin
                    emit_i12(i, k_addi, rd, rj, 12'(rand_below(4096)));
                end
                i++;
            end
        end
        emit_branch(prog_len - 1, k_b, 5'd0, 5'd0, 26'd0); // b to self
    endtask

    task automatic run_model();
        logic [31:0] pc, a, b, v, target;
        int          idx;
        bit          wr;
        for (int r = 0; r < 32; r++) begin
            m_regs[r] = 32'd0;
        end
        pc = reset_pc;
        while (pc != final_pc) begin
            idx    = int'((pc - reset_pc) >> 2);
            a      = m_regs[p_rj[idx]];
            b      = (p_kind[idx] == k_3r) ? m_regs[p_rk[idx]] : p_imm[idx];
            v      = 32'd0;
            wr     = 1'b1;
            target = pc + 32'd4;
            case (p_kind[idx])
                k_3r, k_shift, k_addi: v = alu_model(p_f[idx], a, b);
                k_lu12i: v = b;
                k_ld:    v = m_mem[word_index(a + b)];
                k_st: begin
                    wr = 1'b0;
                    exp_st_addr.push_back(a + b);
                    exp_st_data.push_back(m_regs[p_rd[idx]]);
                    m_mem[word_index(a + b)] = m_regs[p_rd[idx]];
                end
                k_beq, k_bne: begin
                    wr = 1'b0;
                    if ((a == m_regs[p_rd[idx]]) == (p_kind[idx] == k_beq)) begin
                        target = pc + b;
                    end
                end
                k_b: begin
                    wr     = 1'b0;
                    target = pc + b;
                end
                k_bl: begin
                    v      = pc + 32'd4;
                    target = pc + b;
                end
                default: begin // jirl uses rj before the link write
                    v      = pc + 32'd4;
                    target = a + b;
                end
            endcase
            if (wr) begin
                exp_pc.push_back(pc);
                exp_num.push_back(p_rd[idx]);
                exp_val.push_back(v);
                if (p_rd[idx] != 5'd0) begin
                    m_regs[p_rd[idx]] = v;
                end
            end
            pc = target;
        end
    endtask

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        cycles     = 0;
        trace_cnt  = 0;
        store_cnt  = 0;
        fetch_seen = 1'b0;
        for (int w = 0; w < 256; w++) begin
            dmem[w]  = fill_word(w);
            m_mem[w] = fill_word(w);
        end
        build_program();
        run_model();
        exp_writes = exp_pc.size();
        exp_stores = exp_st_addr.size();
        repeat (3) @(posedge clk);
        reset <= 1'b0;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= timeout_cycles) begin
            abort_run("timeout, the program never reached its final branch");
        end else if (reset) begin
            if (cycles > 1) begin // first edge still loads the reset state
                check_value({31'd0, data_we}, 32'd0, "data_we in reset");
                check_value({31'd0, wb_rf_we}, 32'd0, "wb_rf_we in reset");
            end
        end else begin
            if (!fetch_seen) begin
                check_value(inst_addr, reset_pc, "first fetch address");
                fetch_seen = 1'b1;
            end
            if (wb_rf_we) begin
                if (exp_pc.size() == 0) begin
                    abort_run("register write after the last expected one");
                end else begin
                    check_value(wb_pc, exp_pc.pop_front(), "trace pc");
                    check_value({27'd0, wb_rf_wnum}, {27'd0, exp_num.pop_front()},
                                "trace register");
                    check_value(wb_rf_wdata, exp_val.pop_front(), "trace value");
                    trace_cnt++;
                end
            end
            if (data_we) begin
                if (exp_st_addr.size() == 0) begin
                    abort_run("store after the last expected one");
                end else begin
                    check_value(data_addr, exp_st_addr.pop_front(), "store address");
                    check_value(data_wdata, exp_st_data.pop_front(), "store data");
                    store_cnt++;
                end
            end
            if (inst_addr == final_pc) begin
                check_value(32'(trace_cnt), 32'(exp_writes), "register write count");
                check_value(32'(store_cnt), 32'(exp_stores), "store count");
                $display("Everything OK");
                $finish;
            end
        end
    end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the cpu_tb simulation with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing --assert --top-module cpu_tb -f src.f \
    -Mdir obj_dir -o cpu_sim > "$build_log" 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see $build_log"
    exit 1
fi

./obj_dir/cpu_sim > "$sim_log" 2>&1
sim_status=$?
cat "$sim_log"

if grep -q "Something failed" "$sim_log"; then
    echo "simulation FAILED"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulator exited with status $sim_status"
    exit 1
fi
echo "simulation passed"
exit 0

// File: source/alu.sv
`timescale 1ns/1ns

module alu
    import cpu_pkg::*;
(
    input  alu_op_e         alu_op,
    input  logic [xlen-1:0] alu_src1,
    input  logic [xlen-1:0] alu_src2,
    output logic [xlen-1:0] alu_result
);

    logic [4:0]      shamt;
    logic [xlen-1:0] sum;
    logic [xlen-1:0] diff;

    assign shamt = alu_src2[4:0];
    assign sum   = alu_src1 + alu_src2;
    assign diff  = alu_src1 - alu_src2;

    always_comb begin
        case (alu_op)
            op_add:  alu_result = sum;
            op_sub:  alu_result = diff;
            op_slt:  alu_result = {31'd0, $signed(alu_src1) < $signed(alu_src2)};
            op_sltu: alu_result = {31'd0, alu_src1 < alu_src2};
            op_and:  alu_result = alu_src1 & alu_src2;
            op_nor:  alu_result = ~(alu_src1 | alu_src2);
            op_or:   alu_result = alu_src1 | alu_src2;
            op_xor:  alu_result = alu_src1 ^ alu_src2;
            op_sll:  alu_result = alu_src1 << shamt;
            op_srl:  alu_result = alu_src1 >> shamt;
            op_sra:  alu_result = $unsigned($signed(alu_src1) >>> shamt);
            op_lui:  alu_result = alu_src2; // already shifted by decode
            default: alu_result = sum;
        endcase
    end

endmodule

// File: source/cpu_fsm.sv
`timescale 1ns/1ns

module cpu_fsm
    import cpu_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic needs_exec,
    input  logic needs_mem,
    input  logic needs_wb,
    output logic ir_load,
    output logic dec_valid,
    output logic alu_load,
    output logic mem_phase,
    output logic wb_strobe,
    output logic pc_step
);

    cpu_state_e state;
    cpu_state_e state_next;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ph_fetch;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = ph_fetch;
        case (state)
            ph_fetch:  state_next = ph_decode;
            ph_decode: state_next = needs_exec ? ph_exec : ph_fetch; // branches end here
            ph_exec:   state_next = needs_mem ? ph_mem : ph_wb;
            ph_mem:    state_next = needs_wb ? ph_wb : ph_fetch;     // only loads go on
            ph_wb:     state_next = ph_fetch;
            default:   state_next = ph_fetch;
        endcase
    end

    assign ir_load   = (state == ph_fetch);
    assign dec_valid = (state == ph_decode);
    assign alu_load  = (state == ph_exec);
    assign mem_phase = (state == ph_mem);
    assign wb_strobe = (state == ph_wb);

    // last cycle of the instruction
    assign pc_step = (dec_valid && !needs_exec) || (mem_phase && !needs_wb) || wb_strobe;

    assert property (@(posedge clk) disable iff (reset)
        state inside {ph_fetch, ph_decode, ph_exec, ph_mem, ph_wb});

    assert property (@(posedge clk) disable iff (reset)
        !(wb_strobe && mem_phase));

endmodule

// File: source/cpu_pkg.sv
package cpu_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    localparam logic [31:0] reset_pc = 32'h1c00_0000;

    typedef enum logic [2:0] {
        ph_fetch,
        ph_decode,
        ph_exec,
        ph_mem,
        ph_wb
    } cpu_state_e;

    typedef enum logic [3:0] {
        op_add, op_sub, op_slt, op_sltu,
        op_and, op_nor, op_or, op_xor,
        op_sll, op_srl, op_sra, op_lui
    } alu_op_e;

    // bits 31:26
    localparam logic [5:0] opc_alu     = 6'h00;
    localparam logic [5:0] opc_lu12i_w = 6'h05; // also needs bit 25 clear
    localparam logic [5:0] opc_mem     = 6'h0a;
    localparam logic [5:0] opc_jirl    = 6'h13;
    localparam logic [5:0] opc_b       = 6'h14;
    localparam logic [5:0] opc_bl      = 6'h15;
    localparam logic [5:0] opc_beq     = 6'h16;
    localparam logic [5:0] opc_bne     = 6'h17;

    // bits 25:22
    localparam logic [3:0] opc_3r      = 4'h0;
    localparam logic [3:0] opc_shift   = 4'h1;
    localparam logic [3:0] opc_ld_w    = 4'h2;
    localparam logic [3:0] opc_st_w    = 4'h6;
    localparam logic [3:0] opc_addi_w  = 4'ha;

    // bits 21:20
    localparam logic [1:0] opc_3r_grp    = 2'h1;
    localparam logic [1:0] opc_shift_grp = 2'h0;

    // bits 19:15
    localparam logic [4:0] opc_add_w  = 5'h00;
    localparam logic [4:0] opc_sub_w  = 5'h02;
    localparam logic [4:0] opc_slt    = 5'h04;
    localparam logic [4:0] opc_sltu   = 5'h05;
    localparam logic [4:0] opc_nor    = 5'h08;
    localparam logic [4:0] opc_and    = 5'h09;
    localparam logic [4:0] opc_or     = 5'h0a;
    localparam logic [4:0] opc_xor    = 5'h0b;
    localparam logic [4:0] opc_slli_w = 5'h01;
    localparam logic [4:0] opc_srli_w = 5'h09;
    localparam logic [4:0] opc_srai_w = 5'h11;

endpackage

// File: source/cpu_top.sv
`timescale 1ns/1ns

module cpu_top
    import cpu_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    output logic [xlen-1:0]       inst_addr,
    input  logic [xlen-1:0]       inst_rdata,
    output logic                  data_we,
    output logic [xlen-1:0]       data_addr,
    output logic [xlen-1:0]       data_wdata,
    input  logic [xlen-1:0]       data_rdata,
    output logic [xlen-1:0]       wb_pc,
    output logic                  wb_rf_we,
    output logic [reg_addr_w-1:0] wb_rf_wnum,
    output logic [xlen-1:0]       wb_rf_wdata
);

    logic ir_load, dec_valid, alu_load, mem_phase, wb_strobe, pc_step;
    logic needs_exec, needs_mem, needs_wb;
    logic src1_is_pc, src2_is_imm, res_from_mem, mem_we, branch_taken;

    logic [xlen-1:0]       pc, imm, branch_target;
    logic [xlen-1:0]       rj_value, rkd_value;
    logic [reg_addr_w-1:0] rf_raddr1, rf_raddr2, dest;
    alu_op_e               alu_op;

    logic [xlen-1:0] src1_q, src2_q;
    logic [xlen-1:0] alu_result, alu_result_q;
    logic [xlen-1:0] load_data_q;
    logic [xlen-1:0] final_result;

    cpu_fsm u_fsm (
        .clk(clk), .reset(reset),
        .needs_exec(needs_exec), .needs_mem(needs_mem), .needs_wb(needs_wb),
        .ir_load(ir_load), .dec_valid(dec_valid), .alu_load(alu_load),
        .mem_phase(mem_phase), .wb_strobe(wb_strobe), .pc_step(pc_step)
    );

    pc_unit u_pc (
        .clk(clk), .reset(reset), .pc_step(pc_step),
        .branch_taken(branch_taken), .branch_target(branch_target), .pc(pc)
    );

    inst_decode u_dec (
        .clk(clk), .reset(reset), .inst_rdata(inst_rdata), .ir_load(ir_load),
        .pc(pc), .rj_value(rj_value), .rkd_value(rkd_value),
        .rf_raddr1(rf_raddr1), .rf_raddr2(rf_raddr2), .dest(dest), .alu_op(alu_op),
        .src1_is_pc(src1_is_pc), .src2_is_imm(src2_is_imm), .imm(imm),
        .res_from_mem(res_from_mem), .mem_we(mem_we),
        .needs_exec(needs_exec), .needs_mem(needs_mem), .needs_wb(needs_wb),
        .branch_taken(branch_taken), .branch_target(branch_target)
    );

    regfile u_rf (
        .clk(clk), .raddr1(rf_raddr1), .raddr2(rf_raddr2),
        .we(wb_strobe), .waddr(dest), .wdata(final_result),
        .rdata1(rj_value), .rdata2(rkd_value)
    );

    // operands latched in decode
    always_ff @(posedge clk) begin
        if (dec_valid) begin
            src1_q <= src1_is_pc ? pc : rj_value;
            src2_q <= src2_is_imm ? imm : rkd_value;
        end
    end

    alu u_alu (
        .alu_op(alu_op), .alu_src1(src1_q), .alu_src2(src2_q), .alu_result(alu_result)
    );

    always_ff @(posedge clk) begin
        if (alu_load) begin
            alu_result_q <= alu_result;
        end
        if (mem_phase && res_from_mem) begin
            load_data_q <= data_rdata;
        end
    end

    assign final_result = res_from_mem ? load_data_q : alu_result_q;

    assign inst_addr  = pc;
    assign data_we    = mem_we && mem_phase;
    assign data_addr  = alu_result_q;
    assign data_wdata = rkd_value;

    assign wb_pc       = pc;
    assign wb_rf_we    = wb_strobe;
    assign wb_rf_wnum  = dest;
    assign wb_rf_wdata = final_result;

    // store addresses come from the exec sum and must be word aligned
    assert property (@(posedge clk) disable iff (reset)
        data_we |-> data_addr[1:0] == 2'b00);

endmodule

// File: source/inst_decode.sv
`timescale 1ns/1ns

module inst_decode
    import cpu_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic [xlen-1:0]       inst_rdata,
    input  logic                  ir_load,
    input  logic [xlen-1:0]       pc,
    input  logic [xlen-1:0]       rj_value,
    input  logic [xlen-1:0]       rkd_value,
    output logic [reg_addr_w-1:0] rf_raddr1,
    output logic [reg_addr_w-1:0] rf_raddr2,
    output logic [reg_addr_w-1:0] dest,
    output alu_op_e               alu_op,
    output logic                  src1_is_pc,
    output logic                  src2_is_imm,
    output logic [xlen-1:0]       imm,
    output logic                  res_from_mem,
    output logic                  mem_we,
    output logic                  needs_exec,
    output logic                  needs_mem,
    output logic                  needs_wb,
    output logic                  branch_taken,
    output logic [xlen-1:0]       branch_target
);

    typedef enum logic [2:0] {
        ic_nop, ic_alu_reg, ic_alu_imm, ic_load, ic_store, ic_branch, ic_link
    } inst_class_e;

    logic [xlen-1:0] ir;
    inst_class_e     iclass;
    logic [5:0]      op_31_26;
    logic [3:0]      op_25_22;
    logic [1:0]      op_21_20;
    logic [4:0]      op_19_15;
    logic            is_b, is_bl, is_beq, is_bne, is_jirl;
    logic            is_shift;
    logic            rj_eq_rd;
    logic [xlen-1:0] ui5, si12, si20, offs16, offs26;

    always_ff @(posedge clk) begin
        if (reset) begin
            ir <= '0; // decodes as a no-op
        end else if (ir_load) begin
            ir <= inst_rdata;
        end
    end

    assign op_31_26 = ir[31:26];
    assign op_25_22 = ir[25:22];
    assign op_21_20 = ir[21:20];
    assign op_19_15 = ir[19:15];

    assign is_jirl = (op_31_26 == opc_jirl);
    assign is_b    = (op_31_26 == opc_b);
    assign is_bl   = (op_31_26 == opc_bl);
    assign is_beq  = (op_31_26 == opc_beq);
    assign is_bne  = (op_31_26 == opc_bne);

    always_comb begin
        iclass = ic_nop;
        alu_op = op_add; // address and link sums
        if (op_31_26 == opc_alu && op_25_22 == opc_3r && op_21_20 == opc_3r_grp) begin
            iclass = ic_alu_reg;
            case (op_19_15)
                opc_add_w: alu_op = op_add;
                opc_sub_w: alu_op = op_sub;
                opc_slt:   alu_op = op_slt;
                opc_sltu:  alu_op = op_sltu;
                opc_nor:   alu_op = op_nor;
                opc_and:   alu_op = op_and;
                opc_or:    alu_op = op_or;
                opc_xor:   alu_op = op_xor;
                default:   iclass = ic_nop;
            endcase
        end else if (op_31_26 == opc_alu && op_25_22 == opc_shift &&
                     op_21_20 == opc_shift_grp) begin
            iclass = ic_alu_imm;
            case (op_19_15)
                opc_slli_w: alu_op = op_sll;
                opc_srli_w: alu_op = op_srl;
                opc_srai_w: alu_op = op_sra;
                default:    iclass = ic_nop;
            endcase
        end else if (op_31_26 == opc_alu && op_25_22 == opc_addi_w) begin
            iclass = ic_alu_imm;
        end else if (op_31_26 == opc_lu12i_w && !ir[25]) begin
            iclass = ic_alu_imm;
            alu_op = op_lui;
        end else if (op_31_26 == opc_mem && op_25_22 == opc_ld_w) begin
            iclass = ic_load;
        end else if (op_31_26 == opc_mem && op_25_22 == opc_st_w) begin
            iclass = ic_store;
        end else if (is_bl || is_jirl) begin
            iclass = ic_link;
        end else if (is_b || is_beq || is_bne) begin
            iclass = ic_branch;
        end
    end

    assign is_shift = (iclass == ic_alu_imm) &&
                      (alu_op == op_sll || alu_op == op_srl || alu_op == op_sra);

    assign ui5    = {27'd0, ir[14:10]};
    assign si12   = {{20{ir[21]}}, ir[21:10]};
    assign si20   = {ir[24:5], 12'd0};
    assign offs16 = {{14{ir[25]}}, ir[25:10], 2'b00};
    assign offs26 = {{4{ir[9]}}, ir[9:0], ir[25:10], 2'b00};

    always_comb begin
        if (iclass == ic_link) begin
            imm = 32'd4; // link value is pc + 4
        end else if (alu_op == op_lui) begin
            imm = si20;
        end else if (is_shift) begin
            imm = ui5;
        end else begin
            imm = si12;
        end
    end

    assign rj_eq_rd     = (rj_value == rkd_value);
    assign branch_taken = is_b || is_bl || is_jirl || (is_beq && rj_eq_rd) ||
                          (is_bne && !rj_eq_rd);
    assign branch_target = is_jirl ? rj_value + offs16 :
                           pc + ((is_b || is_bl) ? offs26 : offs16);

    assign rf_raddr1 = ir[9:5];
    assign rf_raddr2 = (is_beq || is_bne || iclass == ic_store) ? ir[4:0] : ir[14:10];
    assign dest      = is_bl ? 5'd1 : ir[4:0];

    assign src1_is_pc   = (iclass == ic_link);
    assign src2_is_imm  = (iclass != ic_alu_reg);
    assign res_from_mem = (iclass == ic_load);
    assign mem_we       = (iclass == ic_store);

    assign needs_exec = (iclass != ic_nop) && (iclass != ic_branch);
    assign needs_mem  = (iclass == ic_load) || (iclass == ic_store);
    assign needs_wb   = needs_exec && (iclass != ic_store);

endmodule

// File: source/pc_unit.sv
`timescale 1ns/1ns

module pc_unit
    import cpu_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  logic            pc_step,
    input  logic            branch_taken,
    input  logic [xlen-1:0] branch_target,
    output logic [xlen-1:0] pc
);

    logic [xlen-1:0] seq_pc;

    assign seq_pc = pc + 32'd4;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_pc;
        end else if (pc_step) begin
            pc <= branch_taken ? branch_target : seq_pc;
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        pc[1:0] == 2'b00);

endmodule

// File: source/regfile.sv
`timescale 1ns/1ns

module regfile
    import cpu_pkg::*;
(
    input  logic                  clk,
    input  logic [reg_addr_w-1:0] raddr1,
    input  logic [reg_addr_w-1:0] raddr2,
    input  logic                  we,
    input  logic [reg_addr_w-1:0] waddr,
    input  logic [xlen-1:0]       wdata,
    output logic [xlen-1:0]       rdata1,
    output logic [xlen-1:0]       rdata2
);

    logic [xlen-1:0] regs [0:(1 << reg_addr_w) - 1];

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin // r0 writes dropped
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: src.f
source/cpu_pkg.sv
source/cpu_fsm.sv
source/pc_unit.sv
source/inst_decode.sv
source/regfile.sv
source/alu.sv
source/cpu_top.sv
dv/cpu_tb.sv
